// ==== hw/download_map.sv ====
`timescale 1ns/10ps
`default_nettype none

module download_map
    import game_rom_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ioctl_wr,
    input  logic [SDRAM_AW-1:0]   ioctl_addr,
    input  logic [7:0]            ioctl_data,
    output logic [SDRAM_AW-1:0]   prog_addr,
    output logic [7:0]            prog_data,
    output logic [1:0]            prog_mask,
    output logic                  prog_we,
    output logic [PROM_COUNT-1:0] prom_we
);

    // PROM select and offset fields of the byte address
    localparam int PSW = (PROM_COUNT > 1) ? $clog2(PROM_COUNT) : 1;
    localparam int POW = $clog2(PROM_SIZE);

    logic           in_sdram;
    logic           in_prom;
    logic [PSW-1:0] prom_sel;

    assign in_sdram = ioctl_addr < PROM_BYTE_START;
    assign in_prom  = (ioctl_addr >= PROM_BYTE_START) && (ioctl_addr <= PROM_BYTE_END);
    assign prom_sel = ioctl_addr[POW +: PSW];

    // Byte payload with its lane mask
    always_ff @(posedge clk) begin
        if (ioctl_wr) begin
            prog_data <= ioctl_data;
            // Mask is active low, even bytes go to the low lane
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            if (in_prom) begin
                prog_addr <= SDRAM_AW'(ioctl_addr[POW-1:0]);
            end else begin
                prog_addr <= {1'b0, ioctl_addr[SDRAM_AW-1:1]};
            end
        end
    end

    // Single cycle write strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we <= 1'b0;
            prom_we <= '0;
        end else begin
            prog_we <= ioctl_wr && in_sdram;
            prom_we <= '0;
            if (ioctl_wr && in_prom) begin
                prom_we[prom_sel] <= 1'b1;
            end
            // Bytes past the last PROM raise nothing
        end
    end

endmodule

`default_nettype wire

// ==== hw/game_clocking.sv ====
`timescale 1ns/10ps
`default_nettype none

module game_clocking #(
    parameter int CEN_DIV = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic downloading,
    input  logic rom_ready,
    output logic cen6,
    output logic cen3,
    output logic rst_game
);

    localparam int CW = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;

    logic [CW-1:0] cnt;
    logic          half;
    logic          rst_aux;

    // Divider for the pixel clock enables
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            half <= 1'b0;
            cen6 <= 1'b0;
            cen3 <= 1'b0;
        end else begin
            cen6 <= 1'b0;
            cen3 <= 1'b0;
            if (cnt == CW'(CEN_DIV - 1)) begin
                cnt  <= '0;
                cen6 <= 1'b1;
                // cen3 on every other cen6
                cen3 <= half;
                half <= ~half;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Game reset held until the ROM can be read
    always_ff @(posedge clk) begin
        if (rst || downloading || !rom_ready) begin
            rst_aux  <= 1'b1;
            rst_game <= 1'b1;
        end else begin
            rst_aux  <= 1'b0;
            rst_game <= rst_aux;
        end
    end

endmodule

`default_nettype wire

// ==== hw/game_rom_pkg.sv ====
`default_nettype none

package game_rom_pkg;

    // SDRAM word address, words are 16 bits wide
    localparam int SDRAM_AW = 22;

    // Byte clients
    localparam int MAIN_AW = 17;
    localparam int SND_AW  = 15;

    // Halfword clients
    localparam int CHAR_AW = 14;
    localparam int OBJ_AW  = 16;

    // Region start in SDRAM words
    localparam logic [SDRAM_AW-1:0] MAIN_OFFSET = 22'h00000;
    localparam logic [SDRAM_AW-1:0] SND_OFFSET  = 22'h10000;
    localparam logic [SDRAM_AW-1:0] CHAR_OFFSET = 22'h14000;
    localparam logic [SDRAM_AW-1:0] OBJ_OFFSET  = 22'h18000;
    localparam logic [SDRAM_AW-1:0] PROM_START  = 22'h28000;

    // Colour PROMs come right after the SDRAM regions in the byte stream
    localparam int PROM_COUNT = 4;
    localparam int PROM_SIZE  = 256;
    localparam logic [SDRAM_AW-1:0] PROM_BYTE_START = PROM_START << 1;
    localparam logic [SDRAM_AW-1:0] PROM_BYTE_END =
        SDRAM_AW'(PROM_BYTE_START + PROM_COUNT * PROM_SIZE - 1);

    typedef enum logic [1:0] {
        CLIENT_MAIN,
        CLIENT_SND,
        CLIENT_CHAR,
        CLIENT_OBJ
    } client_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_REQ,
        RD_WAIT
    } rd_state_t;

endpackage

`default_nettype wire

// ==== hw/game_rom_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module game_rom_top
    import game_rom_pkg::*;
#(
    parameter int CEN_DIV = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  downloading,
    // Download stream
    input  logic                  ioctl_wr,
    input  logic [SDRAM_AW-1:0]   ioctl_addr,
    input  logic [7:0]            ioctl_data,
    // ROM clients
    input  logic                  main_cs,
    input  logic [MAIN_AW-1:0]    main_addr,
    output logic [7:0]            main_data,
    output logic                  main_ok,
    input  logic                  snd_cs,
    input  logic [SND_AW-1:0]     snd_addr,
    output logic [7:0]            snd_data,
    output logic                  snd_ok,
    input  logic                  char_cs,
    input  logic [CHAR_AW-1:0]    char_addr,
    output logic [15:0]           char_data,
    output logic                  char_ok,
    input  logic                  obj_cs,
    input  logic [OBJ_AW-1:0]     obj_addr,
    output logic [15:0]           obj_data,
    output logic                  obj_ok,
    // Clock enables and game reset
    output logic                  cen6,
    output logic                  cen3,
    output logic                  rst_game,
    // SDRAM and PROM writes
    output logic [SDRAM_AW-1:0]   prog_addr,
    output logic [7:0]            prog_data,
    output logic [1:0]            prog_mask,
    output logic                  prog_we,
    output logic [PROM_COUNT-1:0] prom_we,
    // SDRAM reads
    output logic                  sdram_req,
    output logic [SDRAM_AW-1:0]   sdram_addr,
    input  logic                  sdram_ack,
    input  logic                  data_rdy,
    input  logic [31:0]           data_read,
    output logic                  refresh_en
);

    logic                rom_ready;
    logic [3:0]          fetch_req;
    logic [3:0]          fetch_done;
    logic [31:0]         fetch_data;
    logic [SDRAM_AW-1:0] main_fetch_addr;
    logic [SDRAM_AW-1:0] snd_fetch_addr;
    logic [SDRAM_AW-1:0] char_fetch_addr;
    logic [SDRAM_AW-1:0] obj_fetch_addr;

    game_clocking #(
        .CEN_DIV     ( CEN_DIV     )
    ) u_clocking (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .rom_ready   ( rom_ready   ),
        .cen6        ( cen6        ),
        .cen3        ( cen3        ),
        .rst_game    ( rst_game    )
    );

    download_map u_download_map (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     )
    );

    rom_slot #(.AW(MAIN_AW), .DW(8), .OFFSET(MAIN_OFFSET)) u_main_slot (
        .clk        ( clk             ),
        .rst        ( rst             ),
        .flush      ( downloading     ),
        .cs         ( main_cs         ),
        .addr       ( main_addr       ),
        .fetch_done ( fetch_done[0]   ),
        .fetch_data ( fetch_data      ),
        .data       ( main_data       ),
        .ok         ( main_ok         ),
        .fetch_req  ( fetch_req[0]    ),
        .fetch_addr ( main_fetch_addr )
    );

    rom_slot #(.AW(SND_AW), .DW(8), .OFFSET(SND_OFFSET)) u_snd_slot (
        .clk        ( clk             ),
        .rst        ( rst             ),
        .flush      ( downloading     ),
        .cs         ( snd_cs          ),
        .addr       ( snd_addr        ),
        .fetch_done ( fetch_done[1]   ),
        .fetch_data ( fetch_data      ),
        .data       ( snd_data        ),
        .ok         ( snd_ok          ),
        .fetch_req  ( fetch_req[1]    ),
        .fetch_addr ( snd_fetch_addr  )
    );

    rom_slot #(.AW(CHAR_AW), .DW(16), .OFFSET(CHAR_OFFSET)) u_char_slot (
        .clk        ( clk             ),
        .rst        ( rst             ),
        .flush      ( downloading     ),
        .cs         ( char_cs         ),
        .addr       ( char_addr       ),
        .fetch_done ( fetch_done[2]   ),
        .fetch_data ( fetch_data      ),
        .data       ( char_data       ),
        .ok         ( char_ok         ),
        .fetch_req  ( fetch_req[2]    ),
        .fetch_addr ( char_fetch_addr )
    );

    rom_slot #(.AW(OBJ_AW), .DW(16), .OFFSET(OBJ_OFFSET)) u_obj_slot (
        .clk        ( clk             ),
        .rst        ( rst             ),
        .flush      ( downloading     ),
        .cs         ( obj_cs          ),
        .addr       ( obj_addr        ),
        .fetch_done ( fetch_done[3]   ),
        .fetch_data ( fetch_data      ),
        .data       ( obj_data        ),
        .ok         ( obj_ok          ),
        .fetch_req  ( fetch_req[3]    ),
        .fetch_addr ( obj_fetch_addr  )
    );

    rom_arbiter u_arbiter (
        .clk         ( clk             ),
        .rst         ( rst             ),
        .downloading ( downloading     ),
        .req         ( fetch_req       ),
        .addr_main   ( main_fetch_addr ),
        .addr_snd    ( snd_fetch_addr  ),
        .addr_char   ( char_fetch_addr ),
        .addr_obj    ( obj_fetch_addr  ),
        .sdram_ack   ( sdram_ack       ),
        .data_rdy    ( data_rdy        ),
        .data_read   ( data_read       ),
        .done        ( fetch_done      ),
        .fetch_data  ( fetch_data      ),
        .sdram_req   ( sdram_req       ),
        .sdram_addr  ( sdram_addr      ),
        .refresh_en  ( refresh_en      ),
        .rom_ready   ( rom_ready       )
    );

endmodule

`default_nettype wire

// ==== hw/rom_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module rom_arbiter
    import game_rom_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                downloading,
    input  logic [3:0]          req,
    input  logic [SDRAM_AW-1:0] addr_main,
    input  logic [SDRAM_AW-1:0] addr_snd,
    input  logic [SDRAM_AW-1:0] addr_char,
    input  logic [SDRAM_AW-1:0] addr_obj,
    input  logic                sdram_ack,
    input  logic                data_rdy,
    input  logic [31:0]         data_read,
    output logic [3:0]          done,
    output logic [31:0]         fetch_data,
    output logic                sdram_req,
    output logic [SDRAM_AW-1:0] sdram_addr,
    output logic                refresh_en,
    output logic                rom_ready
);

    rd_state_t           state;
    client_t             gnt;
    client_t             pick;
    logic [SDRAM_AW-1:0] pick_addr;
    logic                start;
    logic                dl_q;

    // Fixed priority, main first
    always_comb begin
        if (req[0]) begin
            pick = CLIENT_MAIN;
        end else if (req[1]) begin
            pick = CLIENT_SND;
        end else if (req[2]) begin
            pick = CLIENT_CHAR;
        end else begin
            pick = CLIENT_OBJ;
        end
    end

    always_comb begin
        case (pick)
            CLIENT_MAIN: pick_addr = addr_main;
            CLIENT_SND:  pick_addr = addr_snd;
            CLIENT_CHAR: pick_addr = addr_char;
            default:     pick_addr = addr_obj;
        endcase
    end

    // No reads while the ROM is being written
    assign start = (state == RD_IDLE) && !downloading && (|req);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= RD_IDLE;
            sdram_req  <= 1'b0;
            refresh_en <= 1'b0;
        end else begin
            refresh_en <= 1'b0;
            case (state)
                RD_IDLE: begin
                    refresh_en <= !(|req);
                    if (start) begin
                        sdram_req <= 1'b1;
                        state     <= RD_REQ;
                    end
                end
                RD_REQ: begin
                    // Hold request and address until the controller takes them
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= RD_WAIT;
                    end
                end
                RD_WAIT: begin
                    if (data_rdy) begin
                        state <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // Grant and address latched when the read starts
    always_ff @(posedge clk) begin
        if (start) begin
            gnt        <= pick;
            sdram_addr <= pick_addr;
        end
    end

    // Data goes back in the data_rdy cycle, only to the granted slot
    always_comb begin
        done = '0;
        if ((state == RD_WAIT) && data_rdy) begin
            done[gnt] = 1'b1;
        end
    end

    assign fetch_data = data_read;

    // ROM usable from the cycle after download ends
    always_ff @(posedge clk) begin
        if (rst) begin
            dl_q      <= 1'b0;
            rom_ready <= 1'b0;
        end else begin
            dl_q <= downloading;
            if (downloading) begin
                rom_ready <= 1'b0;
            end else if (dl_q) begin
                rom_ready <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/rom_slot.sv ====
`timescale 1ns/10ps
`default_nettype none

module rom_slot
    import game_rom_pkg::*;
#(
    parameter int                  AW     = 17,
    parameter int                  DW     = 8,
    parameter logic [SDRAM_AW-1:0] OFFSET = '0
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                cs,
    input  logic [AW-1:0]       addr,
    input  logic                fetch_done,
    input  logic [31:0]         fetch_data,
    output logic [DW-1:0]       data,
    output logic                ok,
    output logic                fetch_req,
    output logic [SDRAM_AW-1:0] fetch_addr
);

    // Lane select bits, four bytes or two halfwords per word
    localparam int LW = (DW == 8) ? 2 : 1;
    localparam int TW = AW - LW;

    logic [31:0]   word_q;
    logic [TW-1:0] tag_q;
    logic          valid_q;
    logic [TW-1:0] tag;
    logic          hit;

    assign tag = addr[AW-1:LW];
    assign hit = valid_q && (tag_q == tag);
    assign ok  = cs && hit;

    // Lane 0 sits in the low bits of word A
    assign data = word_q[DW * addr[LW-1:0] +: DW];

    // Tag doubled gives the first of the two SDRAM words
    assign fetch_req  = cs && !hit;
    assign fetch_addr = OFFSET + SDRAM_AW'({tag, 1'b0});

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            word_q <= fetch_data;
            tag_q  <= tag;
        end
    end

    // New download content makes the cached word stale
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_q <= 1'b0;
        end else if (fetch_done) begin
            valid_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
hw/game_rom_pkg.sv
hw/game_clocking.sv
hw/download_map.sv
hw/rom_slot.sv
hw/rom_arbiter.sv
hw/game_rom_top.sv
tests/game_rom_chk.sv
tests/sdram_model.sv
tests/tb_game_rom.sv

// ==== tests/game_rom_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module game_rom_chk
    import game_rom_pkg::*;
(
    input logic                clk,
    input logic                rst,
    input logic                downloading,
    input logic                sdram_req,
    input logic                sdram_ack,
    input logic [SDRAM_AW-1:0] sdram_addr,
    input logic [3:0]          done
);

    // Read by the testbench at the end of the run
    int fail_count = 0;

    // Request and address held until the controller acknowledges
    req_held: assert property (@(posedge clk) disable iff (rst)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
        else begin
            fail_count++;
            $error("sdram_req or sdram_addr changed before sdram_ack");
        end

    one_done: assert property (@(posedge clk) disable iff (rst) $onehot0(done))
        else begin
            fail_count++;
            $error("more than one done bit high");
        end

    no_req_in_download: assert property (@(posedge clk) disable iff (rst)
        downloading |-> !sdram_req)
        else begin
            fail_count++;
            $error("sdram_req high during download");
        end

endmodule

`default_nettype wire

// ==== tests/sdram_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module sdram_model #(
    parameter int SEED = 54
) (
    input  logic        clk,
    input  logic        prog_we,
    input  logic [21:0] prog_addr,
    input  logic [7:0]  prog_data,
    input  logic [1:0]  prog_mask,
    input  logic        sdram_req,
    input  logic [21:0] sdram_addr,
    output logic        sdram_ack,
    output logic        data_rdy,
    output logic [31:0] data_read
);

    logic [15:0] mem [logic [21:0]];
    logic [15:0] wr_word;

    // Unwritten words read back a value tied to their full address
    function automatic logic [15:0] read_word(input logic [21:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a[15:0] ^ {a[21:16], a[21:12]};
    endfunction

    // Mask is active low per byte lane
    always @(posedge clk) begin
        if (prog_we) begin
            wr_word = read_word(prog_addr);
            if (!prog_mask[0]) wr_word[7:0] = prog_data;
            if (!prog_mask[1]) wr_word[15:8] = prog_data;
            mem[prog_addr] = wr_word;
        end
    end

    // One read at a time, random ack and data delays
    initial begin
        logic [21:0] rd_addr;
        int          delay;
        void'($urandom(SEED));
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(negedge clk);
            if (sdram_req) begin
                delay = $urandom_range(3, 0);
                repeat (delay) @(negedge clk);
                rd_addr   = sdram_addr;
                sdram_ack = 1'b1;
                @(negedge clk);
                sdram_ack = 1'b0;
                delay = $urandom_range(4, 1);
                repeat (delay - 1) @(negedge clk);
                data_read = {read_word(rd_addr + 22'd1), read_word(rd_addr)};
                data_rdy  = 1'b1;
                @(negedge clk);
                data_rdy  = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_game_rom.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_game_rom
    import game_rom_pkg::*;
();

    localparam int CEN_DIV = 8;
    localparam int TIMEOUT = 200;
    localparam logic [21:0] PROM_FIRST = 22'h50000;
    localparam logic [21:0] PROM_LAST  = 22'h503FF;

    typedef struct packed {
        client_t     client;
        logic [21:0] addr;
        logic [15:0] exp;
    } read_t;

    logic        clk;
    logic        rst;
    logic        downloading;
    logic        ioctl_wr;
    logic [21:0] ioctl_addr;
    logic [7:0]  ioctl_data;
    logic [3:0]  cs;
    logic [21:0] caddr [4];
    wire  [7:0]  main_data;
    wire  [7:0]  snd_data;
    wire  [15:0] char_data;
    wire  [15:0] obj_data;
    wire  [3:0]  ok_vec;
    wire         cen6;
    wire         cen3;
    wire         rst_game;
    wire  [21:0] prog_addr;
    wire  [7:0]  prog_data;
    wire  [1:0]  prog_mask;
    wire         prog_we;
    wire  [3:0]  prom_we;
    wire         sdram_req;
    wire  [21:0] sdram_addr;
    wire         sdram_ack;
    wire         data_rdy;
    wire  [31:0] data_read;
    wire         refresh_en;

    int          errors = 0;
    int          tests = 0;
    read_t       reads[$];
    logic [21:0] addr_log[$];
    logic        req_q;

    game_rom_top #(.CEN_DIV(CEN_DIV)) u_dut (
        .clk(clk), .rst(rst), .downloading(downloading),
        .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
        .main_cs(cs[0]), .main_addr(caddr[0][MAIN_AW-1:0]),
        .main_data(main_data), .main_ok(ok_vec[0]),
        .snd_cs(cs[1]), .snd_addr(caddr[1][SND_AW-1:0]),
        .snd_data(snd_data), .snd_ok(ok_vec[1]),
        .char_cs(cs[2]), .char_addr(caddr[2][CHAR_AW-1:0]),
        .char_data(char_data), .char_ok(ok_vec[2]),
        .obj_cs(cs[3]), .obj_addr(caddr[3][OBJ_AW-1:0]),
        .obj_data(obj_data), .obj_ok(ok_vec[3]),
        .cen6(cen6), .cen3(cen3), .rst_game(rst_game),
        .prog_addr(prog_addr), .prog_data(prog_data), .prog_mask(prog_mask),
        .prog_we(prog_we), .prom_we(prom_we),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr), .sdram_ack(sdram_ack),
        .data_rdy(data_rdy), .data_read(data_read), .refresh_en(refresh_en)
    );

    sdram_model #(.SEED(54)) u_sdram (
        .clk(clk), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .prog_mask(prog_mask),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr), .sdram_ack(sdram_ack),
        .data_rdy(data_rdy), .data_read(data_read)
    );

    bind rom_arbiter game_rom_chk u_chk (
        .clk(clk), .rst(rst), .downloading(downloading),
        .sdram_req(sdram_req), .sdram_ack(sdram_ack), .sdram_addr(sdram_addr),
        .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Address of every new read seen at the SDRAM port
    always @(posedge clk) begin
        if (sdram_req && !req_q) addr_log.push_back(sdram_addr);
        req_q <= sdram_req;
    end

    // Download content for a byte address
    function automatic logic [7:0] pattern_byte(input logic [21:0] a);
        return a[7:0] ^ a[15:8] ^ {6'b0, a[17:16]};
    endfunction

    function automatic logic [21:0] byte_addr(input client_t c, input logic [21:0] a);
        case (c)
            CLIENT_MAIN: return 22'h00000 + a;
            CLIENT_SND:  return 22'h20000 + a;
            CLIENT_CHAR: return 22'h28000 + {a[20:0], 1'b0};
            default:     return 22'h30000 + {a[20:0], 1'b0};
        endcase
    endfunction

    function automatic logic [15:0] expected_data(input client_t c, input logic [21:0] a);
        logic [21:0] b;
        b = byte_addr(c, a);
        if (c == CLIENT_MAIN || c == CLIENT_SND) begin
            return {8'h00, pattern_byte(b)};
        end
        return {pattern_byte(b + 22'd1), pattern_byte(b)};
    endfunction

    // First SDRAM word of the 32-bit group holding the data
    function automatic logic [21:0] fetch_word(input client_t c, input logic [21:0] a);
        logic [21:0] b;
        b = byte_addr(c, a);
        return {1'b0, b[21:2], 1'b0};
    endfunction

    function automatic logic [15:0] client_data(input client_t c);
        case (c)
            CLIENT_MAIN: return {8'h00, main_data};
            CLIENT_SND:  return {8'h00, snd_data};
            CLIENT_CHAR: return char_data;
            default:     return obj_data;
        endcase
    endfunction

    function automatic void add_read(input client_t c, input logic [21:0] a);
        read_t r;
        r.client = c;
        r.addr   = a;
        r.exp    = expected_data(c, a);
        reads.push_back(r);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
        errors++;
    endtask

    task automatic finish_test(input string name, input int mark);
        $display("test %-18s %0d errors", name, errors - mark);
        tests++;
    endtask

    // One byte of the stream, then the registered strobes
    task automatic write_byte(input logic [21:0] a);
        @(negedge clk);
        ioctl_wr   = 1'b1;
        ioctl_addr = a;
        ioctl_data = pattern_byte(a);
        @(negedge clk);
        ioctl_wr   = 1'b0;
        if (rst_game !== 1'b1) report_mismatch("rst_game", rst_game, 1);
        if (prog_data !== pattern_byte(a))
            report_mismatch("prog_data", prog_data, pattern_byte(a));
        if (a < PROM_FIRST) begin
            if (prog_we !== 1'b1) report_mismatch("prog_we", prog_we, 1);
            if (prom_we !== 4'h0) report_mismatch("prom_we", prom_we, 0);
            if (prog_addr !== a >> 1) report_mismatch("prog_addr", prog_addr, a >> 1);
            if (prog_mask !== (a[0] ? 2'b01 : 2'b10))
                report_mismatch("prog_mask", prog_mask, a[0] ? 2'b01 : 2'b10);
        end else if (a <= PROM_LAST) begin
            if (prog_we !== 1'b0) report_mismatch("prog_we", prog_we, 0);
            if (prom_we !== 4'b1 << a[9:8]) report_mismatch("prom_we", prom_we, 4'b1 << a[9:8]);
            if (prog_addr[7:0] !== a[7:0]) report_mismatch("prog_addr", prog_addr, a[7:0]);
        end else begin
            if (prog_we !== 1'b0) report_mismatch("prog_we", prog_we, 0);
            if (prom_we !== 4'h0) report_mismatch("prom_we", prom_we, 0);
        end
    endtask

    task automatic download_range(input logic [21:0] first, input logic [21:0] last);
        for (logic [21:0] a = first; a <= last; a++) begin
            write_byte(a);
        end
    endtask

    // Holds addr until ok, then drops cs
    task automatic read_client(input client_t c, input logic [21:0] a,
                               output logic [15:0] d, output int cycles);
        @(negedge clk);
        cs[c]    = 1'b1;
        caddr[c] = a;
        #1;
        cycles = 0;
        while (!ok_vec[c] && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!ok_vec[c]) begin
            $display("timeout waiting for %s ok at address 0x%0h", c.name(), a);
            errors++;
        end
        d = client_data(c);
        cs[c] = 1'b0;
    endtask

    initial begin
        logic [15:0] d;
        logic [21:0] cont_addr [4];
        int          cycles;
        int          ready_at;
        int          mark;
        int          n;
        int          n6;
        int          n3;
        rst         = 1'b1;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        cs          = '0;
        for (int c = 0; c < 4; c++) caddr[c] = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        mark = errors;
        if (sdram_req !== 1'b0) report_mismatch("sdram_req", sdram_req, 0);
        if (refresh_en !== 1'b0) report_mismatch("refresh_en", refresh_en, 0);
        if (prog_we !== 1'b0) report_mismatch("prog_we", prog_we, 0);
        if (prom_we !== 4'h0) report_mismatch("prom_we", prom_we, 0);
        if (ok_vec !== 4'h0) report_mismatch("ok", ok_vec, 0);
        if (u_dut.rom_ready !== 1'b0) report_mismatch("rom_ready", u_dut.rom_ready, 0);
        if (rst_game !== 1'b1) report_mismatch("rst_game", rst_game, 1);
        finish_test("reset values", mark);

        // Sparse main, snd and obj, full char, all PROMs, then past the end
        mark = errors;
        downloading = 1'b1;
        download_range(22'h00000, 22'h003FF);
        download_range(22'h1FC00, 22'h1FFFF);
        download_range(22'h20000, 22'h203FF);
        download_range(22'h27C00, 22'h27FFF);
        download_range(22'h28000, 22'h2FFFF);
        download_range(22'h30000, 22'h303FF);
        download_range(22'h4FC00, 22'h4FFFF);
        download_range(PROM_FIRST, PROM_LAST);
        download_range(PROM_LAST + 22'd1, PROM_LAST + 22'd4);
        finish_test("download mapping", mark);

        mark = errors;
        @(negedge clk);
        downloading = 1'b0;
        cycles   = 0;
        ready_at = -1;
        while (rst_game && cycles < 20) begin
            @(negedge clk);
            cycles++;
            if (u_dut.rom_ready && ready_at < 0) ready_at = cycles;
        end
        if (rst_game) begin
            $display("timeout waiting for rst_game to fall");
            errors++;
        end
        if (ready_at != 1) report_mismatch("rom_ready cycle", ready_at, 1);
        if (cycles != 3) report_mismatch("rst_game cycle", cycles, 3);
        finish_test("reset sequencing", mark);

        mark = errors;
        add_read(CLIENT_MAIN, 22'h00000);
        add_read(CLIENT_CHAR, 22'h00000);
        add_read(CLIENT_SND,  22'h00000);
        add_read(CLIENT_OBJ,  22'h00000);
        add_read(CLIENT_MAIN, 22'h00013);
        add_read(CLIENT_CHAR, 22'h01234);
        add_read(CLIENT_SND,  22'h00201);
        add_read(CLIENT_OBJ,  22'h001FF);
        add_read(CLIENT_MAIN, 22'h003FE);
        add_read(CLIENT_CHAR, 22'h02A55);
        add_read(CLIENT_SND,  22'h07C10);
        add_read(CLIENT_OBJ,  22'h0FE01);
        add_read(CLIENT_MAIN, 22'h1FC05);
        add_read(CLIENT_CHAR, 22'h03FFF);
        add_read(CLIENT_SND,  22'h07FFF);
        add_read(CLIENT_OBJ,  22'h0FFFF);
        add_read(CLIENT_MAIN, 22'h1FFFF);
        foreach (reads[i]) begin
            read_client(reads[i].client, reads[i].addr, d, cycles);
            if (d !== reads[i].exp) report_mismatch("data", d, reads[i].exp);
        end
        finish_test("table reads", mark);

        // Second access lands in the word fetched by the first
        mark = errors;
        read_client(CLIENT_MAIN, 22'h00100, d, cycles);
        n = addr_log.size();
        read_client(CLIENT_MAIN, 22'h00103, d, cycles);
        if (cycles != 0) report_mismatch("main_ok latency", cycles, 0);
        if (d !== expected_data(CLIENT_MAIN, 22'h00103))
            report_mismatch("main_data", d, expected_data(CLIENT_MAIN, 22'h00103));
        read_client(CLIENT_CHAR, 22'h00200, d, cycles);
        read_client(CLIENT_CHAR, 22'h00201, d, cycles);
        if (cycles != 0) report_mismatch("char_ok latency", cycles, 0);
        if (d !== expected_data(CLIENT_CHAR, 22'h00201))
            report_mismatch("char_data", d, expected_data(CLIENT_CHAR, 22'h00201));
        if (addr_log.size() != n + 1)
            report_mismatch("sdram read count", addr_log.size(), n + 1);
        finish_test("cache hits", mark);

        mark = errors;
        cont_addr[0] = 22'h003F0;
        cont_addr[1] = 22'h00100;
        cont_addr[2] = 22'h00800;
        cont_addr[3] = 22'h00100;
        addr_log.delete();
        @(negedge clk);
        for (int c = 0; c < 4; c++) begin
            cs[c]    = 1'b1;
            caddr[c] = cont_addr[c];
        end
        cycles = 0;
        while (ok_vec != 4'hF && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            // No refresh slot while a read is being requested
            if (sdram_req && refresh_en !== 1'b0)
                report_mismatch("refresh_en", refresh_en, 0);
        end
        if (ok_vec != 4'hF) begin
            $display("timeout waiting for all four clients, ok is 0x%0h", ok_vec);
            errors++;
        end
        for (int c = 0; c < 4; c++) begin
            d = client_data(client_t'(c));
            if (d !== expected_data(client_t'(c), cont_addr[c]))
                report_mismatch("data", d, expected_data(client_t'(c), cont_addr[c]));
        end
        if (addr_log.size() != 4) begin
            $display("SDRAM saw %0d reads under contention instead of 4", addr_log.size());
            errors++;
        end else begin
            for (int c = 0; c < 4; c++) begin
                if (addr_log[c] !== fetch_word(client_t'(c), cont_addr[c])) begin
                    report_mismatch("sdram_addr", addr_log[c],
                                    fetch_word(client_t'(c), cont_addr[c]));
                end
            end
        end
        cs = '0;
        #1;
        if (ok_vec !== 4'h0) report_mismatch("ok", ok_vec, 0);
        // Idle arbiter with nothing pending opens refresh
        @(negedge clk);
        if (refresh_en !== 1'b1) report_mismatch("refresh_en", refresh_en, 1);
        finish_test("priority", mark);

        mark = errors;
        n6 = 0;
        n3 = 0;
        repeat (64) begin
            @(negedge clk);
            n6 += cen6;
            n3 += cen3;
        end
        if (n6 != 64 / CEN_DIV) report_mismatch("cen6 count", n6, 64 / CEN_DIV);
        if (n3 != 32 / CEN_DIV) report_mismatch("cen3 count", n3, 32 / CEN_DIV);
        finish_test("clock enables", mark);

        errors += u_dut.u_arbiter.u_chk.fail_count;
        $display("tests %0d, errors %0d, assertion failures %0d", tests, errors,
                 u_dut.u_arbiter.u_chk.fail_count);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
